// File: src/lockin_pkg.sv
package lockin_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Signal and reference word widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int SIG_WIDTH    = 24;   // Signal word, Q23
    localparam int SC_WIDTH     = 25;   // Sine / cosine word, 25Q24
    localparam int SC_BUS_WIDTH = 64;   // Packed DDS word, cos low, sin at bit 32

    // Final precision of each correlation product
    localparam int CORR_WIDTH   = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Window memory and accumulators
    ////////////////////////////////////////////////////////////////////////////

    localparam int BUF_LEN2 = 4;                   // log2 of window depth
    localparam int BUF_LEN  = 16;                  // Entries per window memory
    localparam int SUM_WIDTH = CORR_WIDTH + BUF_LEN2;  // Growth for BUF_LEN adds

    // Decimation limits
    localparam int DEC_SHIFT_MAX = 6;              // Up to 64 samples per group
    localparam int DEC_ACC_WIDTH = SIG_WIDTH + DEC_SHIFT_MAX;

    // Config exponent, period = 2^n2 decimated points times group length
    localparam int N2_WIDTH = 5;

    // Full product width and the shift back down to CORR_WIDTH
    localparam int PROD_WIDTH = SIG_WIDTH + SC_WIDTH;
    localparam int NORM_SHIFT = PROD_WIDTH - CORR_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [SIG_WIDTH-1:0]     sig_t;      // Input / decimated signal
    typedef logic signed [SC_WIDTH-1:0]      sc_t;       // One reference component
    typedef logic        [SC_BUS_WIDTH-1:0]  sc_bus_t;   // Raw DDS bus

    typedef logic signed [CORR_WIDTH-1:0]    corr_t;     // Normalized product
    typedef logic signed [SUM_WIDTH-1:0]     lck_sum_t;  // Window integral
    typedef logic signed [DEC_ACC_WIDTH-1:0] dec_acc_t;  // Boxcar sum

    typedef logic        [N2_WIDTH-1:0]      n2_t;       // Period exponent
    typedef logic        [BUF_LEN2-1:0]      buf_idx_t;  // Window memory index
    typedef logic        [2:0]               shift_t;    // Decimation shift 0..6

endpackage

// File: src/lockin_config.sv
`timescale 1ns/1ps

module lockin_config
(
    input  logic                 a_clk,
    input  logic                 rst,
    input  logic                 n2_valid,
    input  lockin_pkg::n2_t      n2_in,
    output lockin_pkg::shift_t   dec_shift,
    output logic [5:0]           group_max,
    output lockin_pkg::buf_idx_t win_mask,
    output logic                 cfg_load
);

    import lockin_pkg::*;

    n2_t               n2_reg;      // Current period exponent
    n2_t               n2_excess;   // Part of n2 beyond the window memory
    logic [6:0]        group_len;   // Samples per decimated point, up to 64
    logic [BUF_LEN2:0] win_len;     // Points per window when n2 <= BUF_LEN2

    ////////////////////////////////////////////////////////////////////////////
    // Exponent register and load strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            n2_reg   <= n2_t'(BUF_LEN2);    // One full window, no decimation
            cfg_load <= 1'b0;
        end
        else
        begin
            cfg_load <= n2_valid;           // Pulses with the new decode
            if (n2_valid)
                n2_reg <= n2_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign n2_excess = n2_reg - n2_t'(BUF_LEN2);

    always_comb
    begin
        if (n2_reg > n2_t'(BUF_LEN2))
        begin
            // Long period, decimate to fit BUF_LEN points
            if (n2_excess > n2_t'(DEC_SHIFT_MAX))
                dec_shift = shift_t'(DEC_SHIFT_MAX);    // Clamp
            else
                dec_shift = n2_excess[2:0];
            win_mask = buf_idx_t'(BUF_LEN - 1);
        end
        else
        begin
            // Short period, every sample is a point
            dec_shift = '0;
            win_mask  = buf_idx_t'(win_len - 1'b1);
        end
    end

    assign win_len   = {{BUF_LEN2{1'b0}}, 1'b1} << n2_reg;
    assign group_len = 7'd1 << dec_shift;
    assign group_max = 6'(group_len - 7'd1);    // 64 samples -> 63

endmodule

// File: src/signal_decimator.sv
`timescale 1ns/1ps

module signal_decimator
(
    input  logic                a_clk,
    input  logic                rst,
    input  logic                sample_valid,
    input  lockin_pkg::sig_t    signal_in,
    input  lockin_pkg::sc_bus_t sc_in,
    input  lockin_pkg::shift_t  dec_shift,
    input  logic [5:0]          group_max,
    input  logic                cfg_load,
    output logic                dec_valid,
    output lockin_pkg::sig_t    dec_signal,
    output lockin_pkg::sc_t     dec_sin,
    output lockin_pkg::sc_t     dec_cos
);

    import lockin_pkg::*;

    logic [5:0] group_cnt;      // Samples seen in current group
    dec_acc_t   acc;            // Boxcar sum so far
    dec_acc_t   acc_next;       // Sum including this sample
    dec_acc_t   acc_shifted;    // Group average
    logic       group_done;     // Completing sample of a group

    assign acc_next    = acc + dec_acc_t'(signal_in);   // Sign-extended add
    assign acc_shifted = acc_next >>> dec_shift;
    assign group_done  = sample_valid && (group_cnt == group_max);

    ////////////////////////////////////////////////////////////////////////////
    // Group counter and accumulator
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (rst || cfg_load)
        begin
            group_cnt <= '0;
            acc       <= '0;
            dec_valid <= 1'b0;
        end
        else
        begin
            dec_valid <= group_done;
            if (group_done)
            begin
                group_cnt <= '0;            // Restart the sum
                acc       <= '0;
            end
            else if (sample_valid)
            begin
                group_cnt <= group_cnt + 6'd1;
                acc       <= acc_next;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decimated point with its reference
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (group_done)
        begin
            dec_signal <= sig_t'(acc_shifted);  // Fits after the shift
            // Reference taken with the completing sample
            dec_cos <= sc_t'(sc_in[SC_WIDTH-1:0]);
            dec_sin <= sc_t'(sc_in[SC_BUS_WIDTH/2 +: SC_WIDTH]);
        end
    end

endmodule

// File: src/quad_correlator.sv
`timescale 1ns/1ps

module quad_correlator
(
    input  logic              a_clk,
    input  logic              rst,
    input  logic              dec_valid,
    input  lockin_pkg::sig_t  dec_signal,
    input  lockin_pkg::sc_t   dec_sin,
    input  lockin_pkg::sc_t   dec_cos,
    output logic              prod_valid,
    output lockin_pkg::corr_t prod_x,
    output lockin_pkg::corr_t prod_y
);

    import lockin_pkg::*;

    logic                         stg1_valid;   // Products held in stage 1
    logic signed [PROD_WIDTH-1:0] prod_x_w;     // sin * signal, full width
    logic signed [PROD_WIDTH-1:0] prod_y_w;     // cos * signal, full width

    ////////////////////////////////////////////////////////////////////////////
    // Valid pipe, two items may be in flight
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (rst)
        begin
            stg1_valid <= 1'b0;
            prod_valid <= 1'b0;
        end
        else
        begin
            stg1_valid <= dec_valid;
            prod_valid <= stg1_valid;
        end
    end

    // Stage 1, quadrature products
    always_ff @(posedge a_clk)
    begin
        if (dec_valid)
        begin
            prod_x_w <= dec_sin * dec_signal;   // 25Q24 x Q23
            prod_y_w <= dec_cos * dec_signal;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, normalize to CORR_WIDTH
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (stg1_valid)
        begin
            prod_x <= corr_t'(prod_x_w >>> NORM_SHIFT);   // Keep top bits
            prod_y <= corr_t'(prod_y_w >>> NORM_SHIFT);
        end
    end

endmodule

// File: src/window_integrator.sv
`timescale 1ns/1ps

module window_integrator
(
    input  logic                 a_clk,
    input  logic                 rst,
    input  logic                 prod_valid,
    input  lockin_pkg::corr_t    prod_x,
    input  lockin_pkg::corr_t    prod_y,
    input  lockin_pkg::buf_idx_t win_mask,
    input  logic                 cfg_load,
    output logic                 x_valid,
    output lockin_pkg::lck_sum_t x_sum,
    output lockin_pkg::lck_sum_t y_sum
);

    import lockin_pkg::*;

    // Stored products, one period deep
    corr_t mem_x [BUF_LEN];
    corr_t mem_y [BUF_LEN];

    buf_idx_t          wr_idx;      // Next slot, also the oldest point
    logic [BUF_LEN2:0] fill;        // Points in window, saturates
    logic [BUF_LEN2:0] win_len;     // Window length, 1..BUF_LEN
    logic              win_full;
    corr_t             drop_x;      // Point leaving the window
    corr_t             drop_y;

    assign win_len  = {1'b0, win_mask} + 1'b1;
    assign win_full = (fill == win_len);

    // Slot about to be overwritten holds the point from one window ago
    assign drop_x = win_full ? mem_x[wr_idx] : '0;
    assign drop_y = win_full ? mem_y[wr_idx] : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Moving sums, index and fill count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (rst || cfg_load)
        begin
            x_sum   <= '0;
            y_sum   <= '0;
            wr_idx  <= '0;
            fill    <= '0;
            x_valid <= 1'b0;
        end
        else
        begin
            x_valid <= prod_valid;
            if (prod_valid)
            begin
                // Add newest, drop oldest once full
                x_sum  <= x_sum + lck_sum_t'(prod_x) - lck_sum_t'(drop_x);
                y_sum  <= y_sum + lck_sum_t'(prod_y) - lck_sum_t'(drop_y);
                wr_idx <= (wr_idx + 1'b1) & win_mask;   // Wrap at window length
                if (!win_full)
                    fill <= fill + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window memories
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (prod_valid)
        begin
            mem_x[wr_idx] <= prod_x;    // Read above sees the old entry
            mem_y[wr_idx] <= prod_y;
        end
    end

endmodule

// File: src/lockin_top.sv
`timescale 1ns/1ps

module lockin_top
(
    input  logic                 a_clk,
    input  logic                 rst,
    input  logic                 sample_valid,
    input  lockin_pkg::sig_t     signal_in,
    input  lockin_pkg::sc_bus_t  sc_in,
    input  logic                 n2_valid,
    input  lockin_pkg::n2_t      n2_in,
    output logic                 x_valid,
    output lockin_pkg::lck_sum_t x_sum,
    output lockin_pkg::lck_sum_t y_sum,
    output logic [31:0]          sref_out
);

    import lockin_pkg::*;

    // Config levels and restart strobe
    shift_t     dec_shift;
    logic [5:0] group_max;
    buf_idx_t   win_mask;
    logic       cfg_load;

    // Decimator to correlator
    logic       dec_valid;
    sig_t       dec_signal;
    sc_t        dec_sin;
    sc_t        dec_cos;

    // Correlator to integrator
    logic       prod_valid;
    corr_t      prod_x;
    corr_t      prod_y;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    lockin_config lockin_config_inst
    (
        .a_clk     (a_clk),
        .rst       (rst),
        .n2_valid  (n2_valid),
        .n2_in     (n2_in),
        .dec_shift (dec_shift),
        .group_max (group_max),
        .win_mask  (win_mask),
        .cfg_load  (cfg_load)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute, 1 + 2 cycles
    ////////////////////////////////////////////////////////////////////////////

    signal_decimator signal_decimator_inst
    (
        .a_clk        (a_clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .signal_in    (signal_in),
        .sc_in        (sc_in),
        .dec_shift    (dec_shift),
        .group_max    (group_max),
        .cfg_load     (cfg_load),
        .dec_valid    (dec_valid),
        .dec_signal   (dec_signal),
        .dec_sin      (dec_sin),
        .dec_cos      (dec_cos)
    );

    quad_correlator quad_correlator_inst
    (
        .a_clk      (a_clk),
        .rst        (rst),
        .dec_valid  (dec_valid),
        .dec_signal (dec_signal),
        .dec_sin    (dec_sin),
        .dec_cos    (dec_cos),
        .prod_valid (prod_valid),
        .prod_x     (prod_x),
        .prod_y     (prod_y)
    );

    // Result, one more cycle
    window_integrator window_integrator_inst
    (
        .a_clk      (a_clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod_x     (prod_x),
        .prod_y     (prod_y),
        .win_mask   (win_mask),
        .cfg_load   (cfg_load),
        .x_valid    (x_valid),
        .x_sum      (x_sum),
        .y_sum      (y_sum)
    );

    // Sine reference of latest point, sign-extended
    assign sref_out = {{(32-SC_WIDTH){dec_sin[SC_WIDTH-1]}}, dec_sin};

endmodule

// File: sim/lockin_asserts.sv
`timescale 1ns/1ps

module lockin_asserts
(
    input logic a_clk,
    input logic rst,
    input logic sample_valid,
    input logic n2_valid,
    input logic sample_done,    // Completing sample of a group
    input logic cfg_load,
    input logic dec_valid,
    input logic prod_valid,
    input logic x_valid
);

    // Decimator 1 + correlator 2 + integrator 1
    a_result_latency: assert property (@(posedge a_clk) disable iff (rst)
        x_valid == $past(sample_done, 4))
        else $error("x_valid not 4 cycles after a completing sample");

    // First reset cycle clears the registers
    a_reset_quiet: assert property (@(posedge a_clk)
        (rst && $past(rst)) |->
        !(x_valid || dec_valid || prod_valid || cfg_load || sample_valid || n2_valid))
        else $error("Strobe active during reset");

    a_corr_latency: assert property (@(posedge a_clk) disable iff (rst)
        prod_valid == $past(dec_valid, 2))
        else $error("prod_valid not 2 cycles after dec_valid");

endmodule

bind lockin_top lockin_asserts lockin_asserts_inst
(
    .a_clk        (a_clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .n2_valid     (n2_valid),
    .sample_done  (signal_decimator_inst.group_done),
    .cfg_load     (cfg_load),
    .dec_valid    (dec_valid),
    .prod_valid   (prod_valid),
    .x_valid      (x_valid)
);

// File: sim/lockin_tb.sv
`timescale 1ns/1ps

module lockin_tb;

    import lockin_pkg::*;

    // One test per row
    typedef struct packed
    {
        bit       load;     // Send n2 before the samples
        bit [4:0] n2;
        int       count;    // Sample strobes
        int       gap;      // Idle cycles after each strobe
        bit       rnd;      // Random signal instead of sig
        int       sig;
        int       sn;       // Sine, 25-bit signed range
        int       cs;       // Cosine
    } row_t;

    localparam int N_ROWS = 8;

    row_t rows [N_ROWS] = '{
        '{1'b0, 5'd4,   0, 0, 1'b0, 0, 0, 0},                                // Idle after reset
        '{1'b0, 5'd4,  20, 1, 1'b0, 32'sh040000, 32'sh0400000, 32'sh0200000},  // Default n2
        '{1'b1, 5'd3,  20, 1, 1'b0, 32'sh100000, 32'sh0800000, 32'sh0400000},  // Ramp-up
        '{1'b1, 5'd6,  40, 1, 1'b1, 0, 32'sh0C00000, 32'sh0300000},            // Shift 2
        '{1'b1, 5'd5,  24, 0, 1'b0, 32'sh200000, 32'sh0C00000, -32'sh0A00000}, // Quadrature
        '{1'b1, 5'd7,  36, 2, 1'b1, 0, -32'sh0900000, 32'sh0F00000},           // Partial group
        '{1'b1, 5'd12, 130, 0, 1'b1, 0, 32'sh0FFFFFF, -32'sh1000000},          // Shift clamp
        '{1'b1, 5'd2,  30, 0, 1'b1, 0, 32'sh0B00000, 32'sh0600000}             // Back-to-back
    };

    logic        a_clk;
    logic        rst;
    logic        sample_valid;
    sig_t        signal_in;
    sc_bus_t     sc_in;
    logic        n2_valid;
    n2_t         n2_in;
    logic        x_valid;
    lck_sum_t    x_sum;
    lck_sum_t    y_sum;
    logic [31:0] sref_out;

    integer      seed;
    int          cycle = 0;
    int          cycle_limit;
    int          errors = 0;
    int          checks = 0;
    int          outputs = 0;

    // Reference model state
    int          cur_n2;
    int          grp_cnt;
    longint      grp_acc;
    longint      win_x [$];    // Products inside the window
    longint      win_y [$];

    // Expected results, oldest first
    longint      exp_x [$];
    longint      exp_y [$];
    int          exp_sref [$];
    int          exp_cycle [$];

    lockin_top lockin_top_inst
    (
        .a_clk        (a_clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .signal_in    (signal_in),
        .sc_in        (sc_in),
        .n2_valid     (n2_valid),
        .n2_in        (n2_in),
        .x_valid      (x_valid),
        .x_sum        (x_sum),
        .y_sum        (y_sum),
        .sref_out     (sref_out)
    );

    initial
    begin
        a_clk = 1'b0;
        forever #2 a_clk = ~a_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int model_shift(int n2);
        if (n2 > BUF_LEN2)
            return (n2 - BUF_LEN2 > DEC_SHIFT_MAX) ? DEC_SHIFT_MAX : n2 - BUF_LEN2;
        return 0;
    endfunction

    function automatic int model_window(int n2);
        return (n2 > BUF_LEN2) ? BUF_LEN : (1 << n2);   // Points per period
    endfunction

    task automatic model_reset();
        grp_cnt = 0;
        grp_acc = 0;
        win_x.delete();
        win_y.delete();
    endtask

    task automatic model_sample(input int sig, input int sn, input int cs);
        longint avg;
        longint sx;
        longint sy;
        grp_acc += sig;
        if (grp_cnt == (1 << model_shift(cur_n2)) - 1)
        begin
            avg = grp_acc >>> model_shift(cur_n2);              // Group average
            win_x.push_back(longint'(int'((sn * avg) >>> NORM_SHIFT)));
            win_y.push_back(longint'(int'((cs * avg) >>> NORM_SHIFT)));
            if (win_x.size() > model_window(cur_n2))
            begin
                void'(win_x.pop_front());                       // Oldest leaves
                void'(win_y.pop_front());
            end
            sx = 0;
            sy = 0;
            foreach (win_x[i])
            begin
                sx += win_x[i];
                sy += win_y[i];
            end
            exp_x.push_back(sx);
            exp_y.push_back(sy);
            exp_sref.push_back(sn);
            exp_cycle.push_back(cycle + 4);                     // Fixed latency
            grp_cnt = 0;
            grp_acc = 0;
        end
        else
            grp_cnt++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus, driven on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_config(input int n2);
        @(negedge a_clk);
        n2_valid = 1'b1;
        n2_in    = n2_t'(n2);
        @(negedge a_clk);
        n2_valid = 1'b0;
        @(negedge a_clk);           // cfg_load cycle over
        cur_n2 = n2;
        model_reset();
    endtask

    task automatic send_row(input int r);
        int          sig;
        logic [31:0] rv;
        for (int i = 0; i < rows[r].count; i++)
        begin
            @(negedge a_clk);
            sig = rows[r].sig;
            if (rows[r].rnd)
            begin
                rv  = $random(seed);
                sig = {{8{rv[23]}}, rv[23:0]};    // Full Q23 range
            end
            sample_valid = 1'b1;
            signal_in    = sig_t'(sig);
            sc_in        = {rows[r].sn, rows[r].cs};  // Sine high, cosine low
            model_sample(sig, rows[r].sn, rows[r].cs);
            repeat (rows[r].gap)
            begin
                @(negedge a_clk);
                sample_valid = 1'b0;
            end
        end
        @(negedge a_clk);
        sample_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output checks and watchdog
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_output();
        longint ex;
        longint ey;
        int     es;
        int     ec;
        ex = exp_x.pop_front();
        ey = exp_y.pop_front();
        es = exp_sref.pop_front();
        ec = exp_cycle.pop_front();
        outputs++;
        checks += 4;
        if (cycle != ec)
        begin
            $display("x_valid came at cycle %0d but was due at cycle %0d", cycle, ec);
            errors++;
        end
        if (longint'(x_sum) != ex)
        begin
            $display("FAILED %0t x_sum got %0d expected %0d", $time, x_sum, ex);
            errors++;
        end
        if (longint'(y_sum) != ey)
        begin
            $display("FAILED %0t y_sum got %0d expected %0d", $time, y_sum, ey);
            errors++;
        end
        if (sref_out != es)
        begin
            $display("FAILED %0t sref_out got %h expected %h", $time, sref_out, es);
            errors++;
        end
    endtask

    always @(negedge a_clk)
    begin
        if (!rst && x_valid)
        begin
            if (exp_x.size() == 0)
            begin
                $display("x_valid pulsed at %0t with no result pending", $time);
                errors++;
            end
            else
                check_output();
        end
    end

    always @(posedge a_clk)
    begin
        cycle <= cycle + 1;
        if (cycle > cycle_limit)
        begin
            $display("Run stopped after %0d cycles with %0d results missing",
                     cycle, exp_x.size());
            $display("Regression failed");
            $finish;
        end
    end

    initial
    begin
        int err_start;
        int out_start;
        seed         = 32'h0f6e5700;
        rst          = 1'b1;
        sample_valid = 1'b0;
        signal_in    = '0;
        sc_in        = '0;
        n2_valid     = 1'b0;
        n2_in        = '0;
        cur_n2       = BUF_LEN2;    // Reset decode
        model_reset();
        cycle_limit  = 100;
        for (int r = 0; r < N_ROWS; r++)
            cycle_limit += rows[r].count * (rows[r].gap + 1) + 40;
        repeat (2) @(posedge a_clk);
        @(negedge a_clk);
        rst = 1'b0;

        for (int r = 0; r < N_ROWS; r++)
        begin
            err_start = errors;
            out_start = outputs;
            if (rows[r].load)
                load_config(rows[r].n2);
            send_row(r);
            while (exp_x.size() != 0)
                @(negedge a_clk);
            repeat (6) @(negedge a_clk);    // Quiet gap before next config
            $display("Test %0d n2=%0d samples=%0d outputs=%0d errors=%0d", r, cur_n2,
                     rows[r].count, outputs - out_start, errors - err_start);
        end

        $display("Checks %0d, outputs %0d, errors %0d", checks, outputs, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: flist.f
src/lockin_pkg.sv
src/lockin_config.sv
src/signal_decimator.sv
src/quad_correlator.sv
src/window_integrator.sv
src/lockin_top.sv
sim/lockin_asserts.sv
sim/lockin_tb.sv

// File: Makefile
TOP = lockin_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f flist.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
